// File: hdl/lsu_access_pkg.sv
//////////////////////////////
// core side access definitions
// access size encoding and data word width
//////////////////////////////
`default_nettype none

package lsu_access_pkg;

  // width of core side and bus data words
  parameter int unsigned DataWidth = 32;

  // access size as issued by the decoder
  // both 10 and 11 select a byte access
  typedef enum logic [1:0] {
    LSU_WORD    = 2'b00,
    LSU_HALF    = 2'b01,
    LSU_BYTE    = 2'b10,
    LSU_BYTE_HI = 2'b11
  } lsu_type_e;

endpackage

`default_nettype wire

// File: hdl/lsu_bus_pkg.sv
//////////////////////////////
// data bus geometry
// byte lanes, offset and byte enable types
//////////////////////////////
`default_nettype none

package lsu_bus_pkg;

  parameter int unsigned NumLanes    = 4;  // bytes per bus word
  parameter int unsigned OffsetWidth = 2;  // byte offset bits inside a word

  typedef logic [NumLanes-1:0]    be_t;      // one enable per byte lane
  typedef logic [OffsetWidth-1:0] offset_t;  // byte position inside a word

endpackage

`default_nettype wire

// File: hdl/lsu_ctrl_fsm.sv
//////////////////////////////
// bus sequencing FSM
// split detection, error and write flags
// last address register, response outputs
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // core side
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  lsu_type_e             lsu_type_i,
  input  logic [AddrWidth-1:0]  addr_i,

  // bus side
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  data_err_i,
  output logic                  data_req_o,
  output logic [AddrWidth-1:0]  data_addr_o,

  // to the aligners
  output logic                  second_part_o,
  output logic                  ctrl_update_o,
  output logic                  rdata_update_o,

  // responses
  output logic                  addr_incr_req_o,  // core must present the next word address
  output logic [AddrWidth-1:0]  addr_last_o,
  output logic                  lsu_resp_valid_o,
  output logic                  lsu_rdata_valid_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  output logic                  busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,               // first part waiting for grant
    WAIT_RVALID_MIS,            // first part granted, second part requested
    WAIT_GNT,                   // single or second part waiting for grant
    WAIT_RVALID_MIS_GNTS_DONE   // both granted, first rvalid still due
  } state_e;

  state_e                  state_q, state_d;
  logic                    second_part_q, second_part_d;
  logic                    err_q, err_d;        // first part of a split access erred
  logic                    we_q;                // write flag of the running access
  logic [AddrWidth-1:0]    addr_last_q;
  logic [AddrWidth-1:0]    addr_last_d;
  logic                    addr_update;
  logic                    split_access;
  logic                    any_err;
  offset_t                 offset;

  assign offset = addr_i[OffsetWidth-1:0];

  // word crossing the lane boundary, or half word in lane 3
  assign split_access = ((lsu_type_i == LSU_WORD) && (offset != 2'b00)) ||
                        ((lsu_type_i == LSU_HALF) && (offset == 2'b11));

  //////////////////////////////
  // next state logic
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_part_d   = second_part_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;  // fresh access
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            second_part_d = split_access;
            state_d       = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d       = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          second_part_d = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;  // second part goes out early
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          // second address only recorded if the first part was clean
          addr_update    = data_gnt_i & ~data_err_i;
          second_part_d  = ~data_gnt_i;
          state_d        = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          second_part_d  = 1'b0;
          state_d        = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_part_q;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~err_q;
          second_part_d = 1'b0;
          state_d       = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;  // keeps the second address on addr_i for addr_last
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~we_q;
          state_d        = IDLE;  // second rvalid ends the access in idle
        end
      end

      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      second_part_q <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      err_q         <= err_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_update_o) begin
      we_q <= lsu_we_i;
    end
  end

  // byte address for a single or first part, word address for a second part
  assign addr_last_d = addr_incr_req_o ? data_addr_o : addr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_last_d;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign data_addr_o   = {addr_i[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
  assign second_part_o = second_part_q;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (state_q != IDLE);

  assign any_err           = err_q | data_err_i;  // either part
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~any_err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & any_err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & any_err &  we_q;

endmodule

`default_nettype wire

// File: hdl/lsu_load_align.sv
//////////////////////////////
// load side alignment
// captured access attributes, first read word
// realignment, zero and sign extension
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  ctrl_update_i,   // take attributes of the granted access
  input  logic                  rdata_update_i,  // take first word of a split load
  input  offset_t               offset_i,
  input  lsu_type_e             lsu_type_i,
  input  logic                  sign_ext_i,

  input  logic [DataWidth-1:0]  bus_rdata_i,     // read word from the bus
  output logic [DataWidth-1:0]  rdata_o          // aligned and extended load result
);

  offset_t                 offset_q;   // byte offset of the load
  lsu_type_e               type_q;     // load size
  logic                    sign_ext_q;
  logic [DataWidth-1:8]    rdata_q;    // upper three bytes of the first word

  logic [DataWidth-1:0]    word_val;   // word, joined over two reads if needed
  logic [DataWidth-1:0]    lane_data;  // current word shifted down to the offset
  logic [15:0]             half_val;
  logic [7:0]              byte_val;

  //////////////////////////////
  // capture registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  // byte 0 of the first word never reaches the result
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= bus_rdata_i[DataWidth-1:8];
    end
  end

  //////////////////////////////
  // realignment
  //////////////////////////////

  // split word: low bytes come from the first read, high bytes from the current one
  always_comb begin
    unique case (offset_q)
      2'b00:   word_val = bus_rdata_i;
      2'b01:   word_val = {bus_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   word_val = {bus_rdata_i[15:0], rdata_q[31:16]};
      2'b11:   word_val = {bus_rdata_i[23:0], rdata_q[31:24]};
      default: word_val = bus_rdata_i;
    endcase
  end

  assign lane_data = bus_rdata_i >> {offset_q, 3'b000};

  // only offset 3 makes a half word straddle two words
  assign half_val = (offset_q == 2'b11) ? word_val[15:0] : lane_data[15:0];
  assign byte_val = lane_data[7:0];

  //////////////////////////////
  // extension
  //////////////////////////////

  always_comb begin
    unique case (type_q)
      LSU_WORD:              rdata_o = word_val;
      LSU_HALF:              rdata_o = {{(DataWidth-16){sign_ext_q & half_val[15]}}, half_val};
      LSU_BYTE, LSU_BYTE_HI: rdata_o = {{(DataWidth-8){sign_ext_q & byte_val[7]}}, byte_val};
      default:               rdata_o = word_val;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/lsu_store_align.sv
//////////////////////////////
// store side alignment
// byte enables for first and second part
// write data rotation into byte lanes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
(
  input  lsu_type_e             lsu_type_i,     // access size
  input  offset_t               offset_i,       // byte offset of the original address
  input  logic                  second_part_i,  // high for the upper word of a split access
  input  logic [DataWidth-1:0]  wdata_i,        // store data, lsb aligned
  output be_t                   be_o,
  output logic [DataWidth-1:0]  wdata_o
);

  be_t                      size_mask;  // enables of an aligned access of this size
  logic [2*NumLanes-1:0]    be_span;    // mask placed across two adjacent words

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      LSU_WORD:              size_mask = 4'b1111;
      LSU_HALF:              size_mask = 4'b0011;
      LSU_BYTE, LSU_BYTE_HI: size_mask = 4'b0001;
      default:               size_mask = 4'b1111;
    endcase
  end

  // one enable bit per byte, so the mask moves by the offset in bytes
  // lanes pushed past lane 3 land in the upper half, the second part's enables
  assign be_span = {{NumLanes{1'b0}}, size_mask} << offset_i;
  assign be_o    = second_part_i ? be_span[2*NumLanes-1:NumLanes]  // spilled lanes
                                 : be_span[NumLanes-1:0];          // lanes of first word

  //////////////////////////////
  // write data rotation
  //////////////////////////////

  // rotate left by whole bytes
  // the same word serves both parts of a split store
  always_comb begin
    unique case (offset_i)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      2'b11:   wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
      default: wdata_o = wdata_i;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
//////////////////////////////
// load store unit top level
// store aligner, load aligner, control FSM
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // core side
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  lsu_type_e             lsu_type_i,
  input  logic [DataWidth-1:0]  lsu_wdata_i,
  input  logic                  lsu_sign_ext_i,
  input  logic [AddrWidth-1:0]  addr_i,
  output logic [DataWidth-1:0]  lsu_rdata_o,
  output logic                  lsu_rdata_valid_o,
  output logic                  lsu_resp_valid_o,
  output logic                  addr_incr_req_o,
  output logic [AddrWidth-1:0]  addr_last_o,
  output logic                  load_err_o,
  output logic                  store_err_o,
  output logic                  busy_o,

  // data bus
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  data_err_i,
  output logic [AddrWidth-1:0]  data_addr_o,
  output logic                  data_we_o,
  output be_t                   data_be_o,
  output logic [DataWidth-1:0]  data_wdata_o,
  input  logic [DataWidth-1:0]  data_rdata_i
);

  logic     second_part;
  logic     ctrl_update;
  logic     rdata_update;
  offset_t  offset;

  // while the second part runs the core shows the next word, the original
  // offset then lives on in the last address register
  assign offset    = second_part ? addr_last_o[OffsetWidth-1:0] : addr_i[OffsetWidth-1:0];
  assign data_we_o = lsu_we_i;

  lsu_store_align u_store_align (
    .lsu_type_i    (lsu_type_i),
    .offset_i      (offset),
    .second_part_i (second_part),
    .wdata_i       (lsu_wdata_i),
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .offset_i       (offset),
    .lsu_type_i     (lsu_type_i),
    .sign_ext_i     (lsu_sign_ext_i),
    .bus_rdata_i    (data_rdata_i),
    .rdata_o        (lsu_rdata_o)
  );

  lsu_ctrl_fsm #(
    .AddrWidth (AddrWidth)
  ) u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .addr_i            (addr_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .data_addr_o       (data_addr_o),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .addr_incr_req_o   (addr_incr_req_o),
    .addr_last_o       (addr_last_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_lsu -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_lsu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

// File: tb.f
hdl/lsu_access_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/lsu_store_align.sv
hdl/lsu_load_align.sv
hdl/lsu_ctrl_fsm.sv
hdl/lsu_top.sv
tests/lsu_properties.sv
tests/tb_lsu.sv

// File: tests/lsu_properties.sv
//////////////////////////////
// bound checks on the LSU top level
// bus alignment, response and error rules
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_properties #(
  parameter int unsigned AddrWidth = 32
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  data_req_i,
  input logic [AddrWidth-1:0]  data_addr_i,
  input logic                  resp_valid_i,
  input logic                  rdata_valid_i,
  input logic                  load_err_i,
  input logic                  store_err_i,
  input logic                  busy_i
);

  // bus requests always carry a word address
  req_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i |-> (data_addr_i[1:0] == 2'b00))
    else $error("bus request with unaligned address %h", data_addr_i);

  // a response only arrives once the FSM is back in idle
  resp_not_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |-> !busy_i)
    else $error("response while busy");

  err_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_err_i && store_err_i))
    else $error("load and store error together");

  rdata_in_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rdata_valid_i |-> resp_valid_i)
    else $error("read data valid outside a response");

endmodule

bind lsu_top lsu_properties #(
  .AddrWidth (AddrWidth)
) u_properties (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .data_req_i    (data_req_o),
  .data_addr_i   (data_addr_o),
  .resp_valid_i  (lsu_resp_valid_o),
  .rdata_valid_i (lsu_rdata_valid_o),
  .load_err_i    (load_err_o),
  .store_err_i   (store_err_o),
  .busy_i        (busy_o)
);

`default_nettype wire

// File: tests/lsu_testdata.txt
// num we type sign addr wdata exp_rdata err(0 none 1 load 2 store) exp_addr_last
// hex fields, type 0 word 1 half 2 byte
01 0 0 0 00000010 00000000 49484B4A 0 00000000
02 0 1 1 00000082 00000000 FFFFD9D8 0 00000000
03 0 1 0 00000082 00000000 0000D9D8 0 00000000
04 0 2 1 00000081 00000000 FFFFFFDB 0 00000000
05 0 2 0 00000013 00000000 00000049 0 00000000
06 0 2 1 00000087 00000000 FFFFFFDD 0 00000000
07 0 0 0 00000081 00000000 DED9D8DB 0 00000000
08 0 0 0 00000082 00000000 DFDED9D8 0 00000000
09 0 0 0 00000083 00000000 DCDFDED9 0 00000000
0a 0 1 1 00000083 00000000 FFFFDED9 0 00000000
0b 0 1 0 00000013 00000000 00004E49 0 00000000
0c 1 2 0 00000021 000000A5 00000000 0 00000000
0d 0 0 0 00000020 00000000 7978A57A 0 00000000
0e 1 1 0 00000022 0000BEEF 00000000 0 00000000
0f 0 0 0 00000020 00000000 BEEFA57A 0 00000000
10 1 1 0 00000021 00005566 00000000 0 00000000
11 0 0 0 00000020 00000000 BE55667A 0 00000000
12 1 2 0 00000023 000000C3 00000000 0 00000000
13 0 0 0 00000020 00000000 C355667A 0 00000000
14 1 0 0 00000024 11223344 00000000 0 00000000
15 0 0 0 00000024 00000000 11223344 0 00000000
16 1 0 0 00000029 CAFEF00D 00000000 0 00000000
17 0 0 0 00000028 00000000 FEF00D72 0 00000000
18 0 0 0 0000002C 00000000 757477CA 0 00000000
19 1 1 0 0000002F 00001234 00000000 0 00000000
1a 0 0 0 0000002C 00000000 347477CA 0 00000000
1b 0 0 0 00000030 00000000 69686B12 0 00000000
1c 0 0 0 00000040 00000000 00000000 1 00000040
1d 1 0 0 00000048 00000000 00000000 2 00000048
1e 0 0 0 00000051 00000000 00000000 1 00000051
1f 0 0 0 00000062 00000000 00000000 1 00000064
20 1 1 0 0000006B 00005A5A 00000000 2 0000006C

// File: tests/tb_lsu.sv
//////////////////////////////
// LSU testbench
// core driver, bus memory model with random delays
// checker, watchdog and report
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
();

  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned Fields        = 9;   // words per data file line
  localparam int unsigned MaxTests      = 40;
  localparam int unsigned CyclesPerTest = 40;
  localparam time         ClkPeriod     = 20;
  localparam logic [31:0] Seed          = 32'he6c8_afd7;

  logic                  clk;
  logic                  rst_n;
  logic                  lsu_req, lsu_we, lsu_sign_ext;
  lsu_type_e             lsu_type;
  logic [DataWidth-1:0]  lsu_wdata;
  logic [AddrWidth-1:0]  base_addr;   // address of the access as issued
  logic [AddrWidth-1:0]  core_addr;
  logic [DataWidth-1:0]  lsu_rdata;
  logic                  rdata_valid, resp_valid, addr_incr_req;
  logic                  load_err, store_err, busy;
  logic [AddrWidth-1:0]  addr_last;
  logic                  data_req, data_we, data_gnt, data_rvalid, data_err;
  logic [AddrWidth-1:0]  data_addr;
  be_t                   data_be;
  logic [DataWidth-1:0]  data_wdata, data_rdata;

  logic [7:0]   mem [256];                  // byte wide bus memory
  logic [31:0]  td [MaxTests*Fields];       // data file contents
  logic [31:0]  rsp_data_q [$];             // pending read responses, in order
  logic         rsp_err_q [$];
  int unsigned  rsp_due_q [$];
  int unsigned  cycle, gnt_wait, last_due, grant_cnt;
  logic         fault_en, incr_seen, resp_seen, busy_seen;
  logic [31:0]  fault_word;
  logic [31:0]  got_rdata, got_last;
  logic         got_rdata_valid, got_load_err, got_store_err;
  int unsigned  tests_run, tests_bad, mism_total, idx;
  time          limit;

  // core shows the next word while the second part is requested
  assign core_addr = addr_incr_req ? ((base_addr & ~32'h3) + 32'd4) : base_addr;

  always #(ClkPeriod/2) clk = ~clk;

  lsu_top #(
    .AddrWidth (AddrWidth)
  ) dut_i (
    .clk_i (clk), .rst_ni (rst_n),
    .lsu_req_i (lsu_req), .lsu_we_i (lsu_we), .lsu_type_i (lsu_type),
    .lsu_wdata_i (lsu_wdata), .lsu_sign_ext_i (lsu_sign_ext), .addr_i (core_addr),
    .lsu_rdata_o (lsu_rdata), .lsu_rdata_valid_o (rdata_valid),
    .lsu_resp_valid_o (resp_valid), .addr_incr_req_o (addr_incr_req),
    .addr_last_o (addr_last), .load_err_o (load_err), .store_err_o (store_err),
    .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_err_i (data_err), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata), .data_rdata_i (data_rdata)
  );

  function automatic int unsigned count_tests();
    int unsigned n;
    n = 0;
    while (n < MaxTests && td[n*Fields] != 32'hffff_ffff) n++;  // all ones ends the list
    return n;
  endfunction

  //////////////////////////////
  // bus memory model
  //////////////////////////////

  // accept one granted request, queue its response
  task automatic take_request();
    logic [7:0]   w;
    logic         bad;
    int unsigned  due;
    w   = data_addr[7:0];
    bad = fault_en && (data_addr == fault_word);
    if (data_we && !bad) begin
      for (int i = 0; i < 4; i++) begin
        if (data_be[i]) mem[w + 8'(i)] = data_wdata[8*i +: 8];
      end
    end
    due = cycle + 1 + ($urandom % 2);
    if (due <= last_due) due = last_due + 1;  // keep responses in order
    last_due = due;
    rsp_data_q.push_back({mem[w + 8'd3], mem[w + 8'd2], mem[w + 8'd1], mem[w]});
    rsp_err_q.push_back(bad);
    rsp_due_q.push_back(due);
    grant_cnt++;
  endtask

  always @(posedge clk) begin
    #2;
    cycle++;
    data_gnt = (gnt_wait == 0);
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      data_rvalid = 1'b1;
      data_rdata  = rsp_data_q.pop_front();
      data_err    = rsp_err_q.pop_front();
      void'(rsp_due_q.pop_front());
    end else begin
      data_rvalid = 1'b0;
      data_rdata  = '0;
      data_err    = 1'b0;
    end
  end

  // sample mid cycle where all outputs have settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (data_req && data_gnt) begin
        take_request();
        gnt_wait = $urandom % 4;
      end else if (data_req && gnt_wait > 0) begin
        gnt_wait--;
      end
      if (addr_incr_req) incr_seen = 1'b1;
      if (busy) busy_seen = 1'b1;
      if (resp_valid) begin
        resp_seen       = 1'b1;
        got_rdata       = lsu_rdata;
        got_rdata_valid = rdata_valid;
        got_load_err    = load_err;
        got_store_err   = store_err;
        got_last        = addr_last;
      end
    end
  end

  //////////////////////////////
  // driver and checker
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, inout int unsigned mism);
    assert (got === exp) else begin
      $display("FAIL %0t %s got %08h expected %08h", $time, name, got, exp);
      mism++;
    end
  endtask

  task automatic run_access(input int unsigned n);
    logic [31:0]  num, exp_rdata, err_kind, exp_last;
    logic         split;
    int unsigned  mism;
    num       = td[n*Fields];
    exp_rdata = td[n*Fields+6];
    err_kind  = td[n*Fields+7];   // 0 none, 1 load, 2 store
    exp_last  = td[n*Fields+8];
    mism      = 0;
    @(posedge clk);
    #2;
    // the previous access has answered, so the unit must be idle
    check_value("busy_o", 32'(busy), 32'd0, mism);
    fault_en     = (err_kind != 32'd0);
    fault_word   = exp_last & ~32'h3;  // the erring part's word
    grant_cnt    = 0;
    incr_seen    = 1'b0;
    resp_seen    = 1'b0;
    busy_seen    = 1'b0;
    lsu_we       = td[n*Fields+1][0];
    lsu_type     = lsu_type_e'(td[n*Fields+2][1:0]);
    lsu_sign_ext = td[n*Fields+3][0];
    base_addr    = td[n*Fields+4];
    lsu_wdata    = td[n*Fields+5];
    lsu_req      = 1'b1;
    @(posedge clk);
    #2;
    lsu_req = 1'b0;
    while (!resp_seen) @(posedge clk);
    // words crossing a lane boundary and half words in lane 3 take two requests
    split = (lsu_type == LSU_WORD && base_addr[1:0] != 2'b00) ||
            (lsu_type == LSU_HALF && base_addr[1:0] == 2'b11);
    check_value("bus grants", grant_cnt, split ? 32'd2 : 32'd1, mism);
    check_value("addr_incr_req_o", 32'(incr_seen), 32'(split), mism);
    // a split access waits for its first rvalid outside idle
    if (split) check_value("busy_o", 32'(busy_seen), 32'd1, mism);
    check_value("load_err_o", 32'(got_load_err), 32'(err_kind == 32'd1), mism);
    check_value("store_err_o", 32'(got_store_err), 32'(err_kind == 32'd2), mism);
    check_value("lsu_rdata_valid_o", 32'(got_rdata_valid),
                32'(err_kind == 32'd0 && !lsu_we), mism);
    if (err_kind != 32'd0) check_value("addr_last_o", got_last, exp_last, mism);
    else if (!lsu_we) check_value("lsu_rdata_o", got_rdata, exp_rdata, mism);
    $display("test %0d: %0d mismatches", num, mism);
    tests_run++;
    if (mism != 0) tests_bad++;
    mism_total += mism;
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(Seed));
    clk          = 1'b0;
    rst_n        = 1'b0;
    lsu_req      = 1'b0;
    lsu_we       = 1'b0;
    lsu_sign_ext = 1'b0;
    lsu_type     = LSU_WORD;
    lsu_wdata    = '0;
    base_addr    = '0;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    data_err     = 1'b0;
    data_rdata   = '0;
    cycle        = 0;
    gnt_wait     = 0;
    last_due     = 0;
    grant_cnt    = 0;
    fault_en     = 1'b0;
    fault_word   = '0;
    incr_seen    = 1'b0;
    resp_seen    = 1'b0;
    busy_seen    = 1'b0;
    tests_run    = 0;
    tests_bad    = 0;
    mism_total   = 0;
    for (int a = 0; a < 256; a++) mem[a] = 8'(a) ^ 8'h5A;
    for (int i = 0; i < MaxTests*Fields; i++) td[i] = 32'hffff_ffff;
    $readmemh("tests/lsu_testdata.txt", td);
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    idx = 0;
    while (idx < count_tests()) begin
      run_access(idx);
      idx++;
    end
    $display("tests run %0d, tests with mismatches %0d, mismatches %0d",
             tests_run, tests_bad, mism_total);
    if (tests_bad == 0 && tests_run > 0) $display("Test completed successfully");
    else $display("Test failed");
    $finish;
  end

  // watchdog sized from the number of data lines
  initial begin
    #1;
    limit = time'(count_tests() + 4) * CyclesPerTest * ClkPeriod;
    #limit;
    $display("watchdog expired before all accesses finished");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
